// File: design/adc_acq_pkg.sv
package adc_acq_pkg;

    // circular buffer address, 256 words deep
    typedef logic [7:0] cbuf_addr_t;

    // one buffer word, two packed 12-bit ADC samples
    typedef logic [31:0] adc_word_t;

    // combined enable inputs {enable1, enable0}
    // 0 is disarmed, 1..3 select the fill type
    typedef logic [1:0] fill_type_t;

    // what a 128-bit frame word carries
    typedef enum logic [1:0] {
        KIND_FILL_HDR = 2'd0,
        KIND_WFM_HDR  = 2'd1,
        KIND_DATA     = 2'd2,
        KIND_CHECKSUM = 2'd3
    } frame_kind_t;

    // fill header payload: [15:0] fill number, [17:16] fill type, [31:24] burst count
    // waveform header payload: [7:0] trigger address
    // checksum payload: [31:0] sum of the fill's data words
    typedef struct packed {
        frame_kind_t  kind;
        logic [127:0] payload;
    } frame_word_t;

    // registered strobes from the sequencer
    typedef struct packed {
        logic fill_hdr_sel;
        logic wfm_hdr_sel;
        logic dat_sel;
        logic checksum_sel;
        logic checksum_update;
        logic frame_wr;
        logic burst_cntr_init;
        logic burst_cntr_en;
        logic fill_cntr_en;
        logic latch_burst;
    } acq_ctrl_t;

endpackage

// File: design/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int DEPTH = 2
) (
    input  logic     clk,
    input  logic     adc_acq_full_reset,
    input  payload_t wr_data,
    input  logic     wr_valid,
    output logic     wr_ready,
    output payload_t rd_data,
    output logic     rd_valid,
    input  logic     rd_ready,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign wr_ready = (count != CNT_W'(DEPTH));
    assign rd_valid = (count != '0);
    assign empty    = (count == '0);
    // show-ahead, head word is always on the output
    assign rd_data  = mem[rd_ptr];

    // a push into a full FIFO is dropped
    assign do_wr = wr_valid & wr_ready;
    assign do_rd = rd_ready & rd_valid;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // occupancy only moves when exactly one side transfers
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: design/adc_acq_sequencer.sv
`timescale 1ns/1ns

module adc_acq_sequencer (
    input  logic                   clk,
    input  logic                   adc_acq_full_reset,
    input  logic                   acq_enable0,
    input  logic                   acq_enable1,
    input  logic                   acq_trig,
    input  logic                   burst_cntr_zero,
    input  logic                   frame_fifo_ready,
    input  logic                   frame_fifo_empty,
    output adc_acq_pkg::fill_type_t fill_type,
    output adc_acq_pkg::acq_ctrl_t  ctrl,
    output logic                   trig_capture,
    output logic                   trig_pop,
    output logic                   acq_done,
    output logic                   acq_enabled,
    output logic                   sm_idle
);

    import adc_acq_pkg::*;

    // one-hot state indices
    localparam int IDLE           = 0;
    localparam int WATCH_FOR_TRIG = 1;
    localparam int FILL_INIT1     = 2;
    localparam int FILL_INIT2     = 3;
    localparam int WAVEFORM_INIT1 = 4;
    localparam int WAVEFORM_INIT2 = 5;
    localparam int WAVEFORM_INIT3 = 6;
    localparam int RUN1           = 7;
    localparam int RUN2           = 8;
    localparam int RUN3           = 9;
    localparam int RUN4           = 10;
    localparam int WAVEFORM_TST1  = 11;
    localparam int WAVEFORM_TST2  = 12;
    localparam int CHECKSUM1      = 13;
    localparam int CHECKSUM2      = 14;
    localparam int DRAIN_WAIT     = 15;
    localparam int DONE           = 16;
    localparam int NUM_STATES     = 17;

    logic [3:0]            en0_sync;
    logic [3:0]            en1_sync;
    logic [3:0]            trig_sync;
    logic                  armed;
    logic [NUM_STATES-1:0] cs;
    logic [NUM_STATES-1:0] ns;

    // enables and trigger come from another domain, four flops each
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            en0_sync  <= '0;
            en1_sync  <= '0;
            trig_sync <= '0;
            armed     <= 1'b0;
            fill_type <= '0;
        end else begin
            en0_sync  <= {en0_sync[2:0], acq_enable0};
            en1_sync  <= {en1_sync[2:0], acq_enable1};
            trig_sync <= {trig_sync[2:0], acq_trig};
            // armed whenever either enable is set
            armed     <= en0_sync[3] | en1_sync[3];
            fill_type <= {en1_sync[3], en0_sync[3]};
        end
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            cs       <= '0;
            cs[IDLE] <= 1'b1;
        end else begin
            cs <= ns;
        end
    end

    // write states are only entered with room in the frame FIFO,
    // the state in front of each one holds until then
    always_comb begin
        ns = '0;
        case (1'b1)
            cs[IDLE]: begin
                if (armed) ns[WATCH_FOR_TRIG] = 1'b1;
                else       ns[IDLE] = 1'b1;
            end
            // only a trigger moves us forward, disarm drops back to idle
            cs[WATCH_FOR_TRIG]: begin
                if (trig_sync[3]) ns[FILL_INIT1] = 1'b1;
                else if (armed)   ns[WATCH_FOR_TRIG] = 1'b1;
                else              ns[IDLE] = 1'b1;
            end
            cs[FILL_INIT1]: begin
                if (frame_fifo_ready) ns[FILL_INIT2] = 1'b1;
                else                  ns[FILL_INIT1] = 1'b1;
            end
            cs[FILL_INIT2]:     ns[WAVEFORM_INIT1] = 1'b1;
            cs[WAVEFORM_INIT1]: ns[WAVEFORM_INIT2] = 1'b1;
            cs[WAVEFORM_INIT2]: begin
                if (frame_fifo_ready) ns[WAVEFORM_INIT3] = 1'b1;
                else                  ns[WAVEFORM_INIT2] = 1'b1;
            end
            cs[WAVEFORM_INIT3]: ns[RUN1] = 1'b1;
            cs[RUN1]:           ns[RUN2] = 1'b1;
            cs[RUN2]:           ns[RUN3] = 1'b1;
            cs[RUN3]: begin
                if (frame_fifo_ready) ns[RUN4] = 1'b1;
                else                  ns[RUN3] = 1'b1;
            end
            // loop for another burst until the counter runs out
            cs[RUN4]: begin
                if (burst_cntr_zero) ns[WAVEFORM_TST1] = 1'b1;
                else                 ns[RUN1] = 1'b1;
            end
            // single waveform per fill, so the test always falls through
            cs[WAVEFORM_TST1]: ns[WAVEFORM_TST2] = 1'b1;
            cs[WAVEFORM_TST2]: ns[CHECKSUM1] = 1'b1;
            cs[CHECKSUM1]: begin
                if (frame_fifo_ready) ns[CHECKSUM2] = 1'b1;
                else                  ns[CHECKSUM1] = 1'b1;
            end
            cs[CHECKSUM2]: ns[DRAIN_WAIT] = 1'b1;
            // all frame words must have left before we report done
            cs[DRAIN_WAIT]: begin
                if (frame_fifo_empty) ns[DONE] = 1'b1;
                else                  ns[DRAIN_WAIT] = 1'b1;
            end
            // hold off a retrigger from a trigger level still high
            cs[DONE]: begin
                if (armed && trig_sync[3]) ns[DONE] = 1'b1;
                else                       ns[IDLE] = 1'b1;
            end
            default: ns[IDLE] = 1'b1;
        endcase
    end

    // strobes line up with the cycle the next state is entered
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            ctrl         <= '0;
            trig_capture <= 1'b0;
            trig_pop     <= 1'b0;
            acq_done     <= 1'b0;
            acq_enabled  <= 1'b0;
            sm_idle      <= 1'b1;
        end else begin
            ctrl.fill_hdr_sel    <= ns[FILL_INIT2];
            ctrl.wfm_hdr_sel     <= ns[WAVEFORM_INIT3];
            ctrl.dat_sel         <= ns[RUN4];
            ctrl.checksum_sel    <= ns[CHECKSUM2];
            ctrl.checksum_update <= ns[RUN4];
            ctrl.frame_wr        <= ns[FILL_INIT2] | ns[WAVEFORM_INIT3] |
                                    ns[RUN4] | ns[CHECKSUM2];
            // read address and waveform address both load from the FIFO head
            ctrl.burst_cntr_init <= ns[WAVEFORM_INIT2];
            ctrl.burst_cntr_en   <= ns[RUN1];
            ctrl.fill_cntr_en    <= ns[CHECKSUM2];
            ctrl.latch_burst     <= ns[RUN1];
            trig_capture         <= cs[WATCH_FOR_TRIG] & ns[FILL_INIT1];
            // set by WAVEFORM_INIT1, pops the head once INIT2 has used it
            trig_pop             <= cs[WAVEFORM_INIT1];
            // one pulse per fill, not repeated while DONE holds
            acq_done             <= cs[DRAIN_WAIT] & ns[DONE];
            acq_enabled          <= ~(ns[IDLE] | ns[WATCH_FOR_TRIG]);
            sm_idle              <= ns[IDLE];
        end
    end

endmodule

// File: design/circ_buf_reader.sv
`timescale 1ns/1ns

module circ_buf_reader #(
    parameter int PRETRIG_WORDS = 16
) (
    input  logic                   clk,
    input  logic                   adc_acq_full_reset,
    input  adc_acq_pkg::adc_word_t  adc_word,
    input  logic                   adc_valid,
    input  logic                   trig_capture,
    input  logic                   trig_addr_ready,
    input  adc_acq_pkg::cbuf_addr_t trig_addr,
    input  logic                   trig_addr_valid,
    input  adc_acq_pkg::acq_ctrl_t  ctrl,
    output adc_acq_pkg::cbuf_addr_t trig_addr_wr,
    output logic                   trig_addr_wr_valid,
    output logic [127:0]           burst_data
);

    import adc_acq_pkg::*;

    localparam int BUF_WORDS = 2 ** $bits(cbuf_addr_t);

    adc_word_t  mem [BUF_WORDS];
    cbuf_addr_t wr_addr;
    cbuf_addr_t rd_addr;
    cbuf_addr_t rd_addr_nxt;
    adc_word_t  rd_q;
    adc_word_t  word0;
    adc_word_t  word1;
    adc_word_t  word2;
    logic       gather1;
    logic       gather2;
    logic       rd_advance;

    // start of the saved window, PRETRIG_WORDS behind the writer
    assign trig_addr_wr       = wr_addr - cbuf_addr_t'(PRETRIG_WORDS);
    // drop the address when the trigger FIFO is full
    assign trig_addr_wr_valid = trig_capture & trig_addr_ready;

    // step through words 0..2 during RUN1..RUN3 and past word 3 when the burst is written
    assign rd_advance  = ctrl.latch_burst | gather1 | gather2 | (ctrl.dat_sel & ctrl.frame_wr);
    assign rd_addr_nxt = (ctrl.burst_cntr_init && trig_addr_valid) ? trig_addr :
                         rd_advance ? rd_addr + 1'b1 : rd_addr;

    // word 3 comes straight from the RAM and holds until the burst is written
    assign burst_data = {rd_q, word2, word1, word0};

    // RAM is read at the next address, so rd_q always matches rd_addr
    always_ff @(posedge clk) begin
        if (adc_valid) begin
            mem[wr_addr] <= adc_word;
        end
        rd_q <= mem[rd_addr_nxt];
        if (ctrl.latch_burst) word0 <= rd_q;
        if (gather1)          word1 <= rd_q;
        if (gather2)          word2 <= rd_q;
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            wr_addr <= '0;
            rd_addr <= '0;
            gather1 <= 1'b0;
            gather2 <= 1'b0;
        end else begin
            if (adc_valid) begin
                wr_addr <= wr_addr + 1'b1;
            end
            rd_addr <= rd_addr_nxt;
            gather1 <= ctrl.latch_burst;
            gather2 <= gather1;
        end
    end

endmodule

// File: design/frame_assembler.sv
`timescale 1ns/1ns

module frame_assembler (
    input  logic                     clk,
    input  logic                     adc_acq_full_reset,
    input  adc_acq_pkg::acq_ctrl_t    ctrl,
    input  adc_acq_pkg::fill_type_t   fill_type,
    input  logic [7:0]               burst_count_0,
    input  logic [7:0]               burst_count_1,
    input  adc_acq_pkg::cbuf_addr_t   trig_addr,
    input  logic [127:0]             burst_data,
    output adc_acq_pkg::frame_word_t  frame_wr_data,
    output logic                     burst_cntr_zero
);

    import adc_acq_pkg::*;

    logic [7:0]  burst_sel;
    logic [7:0]  burst_len;
    logic [7:0]  burst_cntr;
    logic [15:0] fill_number;
    cbuf_addr_t  wfm_addr;
    logic [31:0] checksum;
    logic [31:0] burst_sum;

    // type 1 runs on count 0, types 2 and 3 on count 1
    assign burst_sel = (fill_type == fill_type_t'(1)) ? burst_count_0 : burst_count_1;
    // a zero count still gives one burst
    assign burst_len = (burst_sel == '0) ? 8'd1 : burst_sel;

    assign burst_cntr_zero = (burst_cntr == '0);

    // four data words of the burst now on the mux
    assign burst_sum = burst_data[31:0] + burst_data[63:32] +
                       burst_data[95:64] + burst_data[127:96];

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            burst_cntr  <= '0;
            fill_number <= '0;
        end else begin
            if (ctrl.burst_cntr_init) begin
                burst_cntr <= burst_len;
            end else if (ctrl.burst_cntr_en && !burst_cntr_zero) begin
                burst_cntr <= burst_cntr - 1'b1;
            end
            if (ctrl.fill_cntr_en) begin
                fill_number <= fill_number + 1'b1;
            end
        end
    end

    // head of the trigger FIFO is taken before it is popped
    always_ff @(posedge clk) begin
        if (ctrl.burst_cntr_init) begin
            wfm_addr <= trig_addr;
        end
        // restart the sum with every fill header
        if (ctrl.fill_hdr_sel) begin
            checksum <= '0;
        end else if (ctrl.checksum_update) begin
            checksum <= checksum + burst_sum;
        end
    end

    // selects are high in the same cycle as frame_wr
    always_comb begin
        frame_wr_data = '0;
        if (ctrl.fill_hdr_sel) begin
            frame_wr_data.kind           = KIND_FILL_HDR;
            frame_wr_data.payload[15:0]  = fill_number;
            frame_wr_data.payload[17:16] = fill_type;
            frame_wr_data.payload[31:24] = burst_len;
        end else if (ctrl.wfm_hdr_sel) begin
            frame_wr_data.kind          = KIND_WFM_HDR;
            frame_wr_data.payload[7:0]  = wfm_addr;
        end else if (ctrl.dat_sel) begin
            frame_wr_data.kind    = KIND_DATA;
            frame_wr_data.payload = burst_data;
        end else if (ctrl.checksum_sel) begin
            frame_wr_data.kind          = KIND_CHECKSUM;
            frame_wr_data.payload[31:0] = checksum;
        end
    end

endmodule

// File: design/adc_acq_top.sv
`timescale 1ns/1ns

module adc_acq_top #(
    parameter int PRETRIG_WORDS    = 16,
    parameter int FRAME_FIFO_DEPTH = 16,
    parameter int TRIG_FIFO_DEPTH  = 2
) (
    input  logic                    clk,
    input  logic                    adc_acq_full_reset,
    input  adc_acq_pkg::adc_word_t   adc_word,
    input  logic                    adc_valid,
    input  logic                    acq_enable0,
    input  logic                    acq_enable1,
    input  logic                    acq_trig,
    input  logic [7:0]              burst_count_0,
    input  logic [7:0]              burst_count_1,
    input  logic                    frame_ready,
    output adc_acq_pkg::frame_word_t frame_out,
    output logic                    frame_valid,
    output logic                    acq_done,
    output logic                    acq_enabled,
    output logic                    sm_idle
);

    import adc_acq_pkg::*;

    acq_ctrl_t    ctrl;
    fill_type_t   fill_type;
    logic         trig_capture;
    logic         trig_pop;
    cbuf_addr_t   trig_addr_wr;
    logic         trig_addr_wr_valid;
    logic         trig_addr_ready;
    cbuf_addr_t   trig_addr;
    logic         trig_addr_valid;
    logic [127:0] burst_data;
    frame_word_t  frame_wr_data;
    logic         burst_cntr_zero;
    logic         frame_fifo_ready;
    logic         frame_fifo_empty;

    adc_acq_sequencer adc_acq_sequencer_inst (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .acq_enable0        (acq_enable0),
        .acq_enable1        (acq_enable1),
        .acq_trig           (acq_trig),
        .burst_cntr_zero    (burst_cntr_zero),
        .frame_fifo_ready   (frame_fifo_ready),
        .frame_fifo_empty   (frame_fifo_empty),
        .fill_type          (fill_type),
        .ctrl               (ctrl),
        .trig_capture       (trig_capture),
        .trig_pop           (trig_pop),
        .acq_done           (acq_done),
        .acq_enabled        (acq_enabled),
        .sm_idle            (sm_idle)
    );

    circ_buf_reader #(
        .PRETRIG_WORDS (PRETRIG_WORDS)
    ) circ_buf_reader_inst (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .adc_word           (adc_word),
        .adc_valid          (adc_valid),
        .trig_capture       (trig_capture),
        .trig_addr_ready    (trig_addr_ready),
        .trig_addr          (trig_addr),
        .trig_addr_valid    (trig_addr_valid),
        .ctrl               (ctrl),
        .trig_addr_wr       (trig_addr_wr),
        .trig_addr_wr_valid (trig_addr_wr_valid),
        .burst_data         (burst_data)
    );

    // trigger addresses wait here until their fill reaches the waveform header
    sync_fifo #(
        .payload_t (cbuf_addr_t),
        .DEPTH     (TRIG_FIFO_DEPTH)
    ) trig_fifo_inst (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .wr_data            (trig_addr_wr),
        .wr_valid           (trig_addr_wr_valid),
        .wr_ready           (trig_addr_ready),
        .rd_data            (trig_addr),
        .rd_valid           (trig_addr_valid),
        .rd_ready           (trig_pop),
        .empty              ()
    );

    frame_assembler frame_assembler_inst (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .ctrl               (ctrl),
        .fill_type          (fill_type),
        .burst_count_0      (burst_count_0),
        .burst_count_1      (burst_count_1),
        .trig_addr          (trig_addr),
        .burst_data         (burst_data),
        .frame_wr_data      (frame_wr_data),
        .burst_cntr_zero    (burst_cntr_zero)
    );

    sync_fifo #(
        .payload_t (frame_word_t),
        .DEPTH     (FRAME_FIFO_DEPTH)
    ) frame_fifo_inst (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .wr_data            (frame_wr_data),
        .wr_valid           (ctrl.frame_wr),
        .wr_ready           (frame_fifo_ready),
        .rd_data            (frame_out),
        .rd_valid           (frame_valid),
        .rd_ready           (frame_ready),
        .empty              (frame_fifo_empty)
    );

endmodule

// File: tb/adc_acq_tb.sv
`timescale 1ns/1ns

module adc_acq_tb;

    import adc_acq_pkg::*;

    localparam int PRETRIG_WORDS = 16;
    localparam int NUM_ROWS      = 7;

    // one line of the stimulus table
    typedef struct packed {
        fill_type_t enables;
        logic [7:0] bc0;
        logic [7:0] bc1;
        logic [7:0] hold;
        logic [1:0] fills;
    } stim_row_t;

    // position of the frame checker inside a fill
    typedef enum logic [2:0] {
        WANT_FILL_HDR,
        WANT_WFM_HDR,
        WANT_DATA,
        WANT_CHECKSUM,
        WANT_DONE
    } check_state_t;

    logic         clk;
    logic         adc_acq_full_reset;
    adc_word_t    adc_word;
    logic         adc_valid;
    logic         acq_enable0;
    logic         acq_enable1;
    logic         acq_trig;
    logic [7:0]   burst_count_0;
    logic [7:0]   burst_count_1;
    logic         frame_ready;
    frame_word_t  frame_out;
    logic         frame_valid;
    logic         acq_done;
    logic         acq_enabled;
    logic         sm_idle;

    stim_row_t    rows [NUM_ROWS];
    logic [15:0]  lfsr;
    int           cycle_count;
    int           cycle_limit;
    int           fills_total;
    int           done_count;
    int           bursts_left;
    int           r;
    logic         quiet;
    logic         first_word;
    check_state_t chk_state;
    logic [15:0]  fill_idx;
    fill_type_t   exp_type;
    logic [7:0]   exp_count;
    cbuf_addr_t   wfm_addr;
    logic [31:0]  next_word;
    logic [31:0]  data_sum;
    logic [31:0]  trig_word;

    adc_acq_top adc_acq_top_inst (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .adc_word           (adc_word),
        .adc_valid          (adc_valid),
        .acq_enable0        (acq_enable0),
        .acq_enable1        (acq_enable1),
        .acq_trig           (acq_trig),
        .burst_count_0      (burst_count_0),
        .burst_count_1      (burst_count_1),
        .frame_ready        (frame_ready),
        .frame_out          (frame_out),
        .frame_valid        (frame_valid),
        .acq_done           (acq_done),
        .acq_enabled        (acq_enabled),
        .sm_idle            (sm_idle)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_kind(input string name, input frame_kind_t got, input frame_kind_t exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_addr(input string name, input cbuf_addr_t got, input cbuf_addr_t exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // data words and the checksum are both plain 32-bit words
    task automatic verify_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic match_fill_number(input string name, input logic [15:0] got,
                                     input logic [15:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_fill_type(input string name, input fill_type_t got, input fill_type_t exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_count(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // type 1 runs on count 0, the others on count 1, zero means one burst
    function automatic logic [7:0] bursts_for_row(input stim_row_t row);
        logic [7:0] n;
        n = (row.enables == 2'd1) ? row.bc0 : row.bc1;
        if (n == 8'd0) begin
            n = 8'd1;
        end
        return n;
    endfunction

    // settle, arming, trigger, fill at half output rate, quiet tail
    function automatic int row_cycles(input stim_row_t row);
        return 32 + int'(row.hold) + 60 + 16 * (int'(bursts_for_row(row)) + 3);
    endfunction

    task automatic take_frame(input frame_word_t fw);
        logic [31:0] w;
        int          lag;
        int          i;
        case (chk_state)
            WANT_FILL_HDR: begin
                check_kind("fill header kind", fw.kind, KIND_FILL_HDR);
                match_fill_number("fill number", fw.payload[15:0], fill_idx);
                check_fill_type("fill type", fw.payload[17:16], exp_type);
                compare_count("burst count", fw.payload[31:24], exp_count);
                bursts_left = int'(exp_count);
                data_sum    = '0;
                chk_state   = WANT_WFM_HDR;
            end
            WANT_WFM_HDR: begin
                check_kind("waveform header kind", fw.kind, KIND_WFM_HDR);
                wfm_addr   = fw.payload[7:0];
                first_word = 1'b1;
                chk_state  = WANT_DATA;
            end
            WANT_DATA: begin
                check_kind("data kind", fw.kind, KIND_DATA);
                // earliest word sits in the low 32 bits
                for (i = 0; i < 4; i++) begin
                    w = fw.payload[32*i +: 32];
                    if (first_word) begin
                        compare_addr("first data address", w[7:0], wfm_addr);
                        lag = int'(trig_word) - int'(w);
                        if (lag <= 0 || lag > PRETRIG_WORDS + 8) begin
                            stop_run($sformatf("first data word %0d too far from trigger word %0d",
                                               w, trig_word));
                        end
                        first_word = 1'b0;
                    end else begin
                        verify_word("data word", w, next_word);
                    end
                    next_word = w + 32'd1;
                    data_sum  = data_sum + w;
                end
                bursts_left--;
                if (bursts_left == 0) begin
                    chk_state = WANT_CHECKSUM;
                end
            end
            WANT_CHECKSUM: begin
                check_kind("checksum kind", fw.kind, KIND_CHECKSUM);
                verify_word("checksum", fw.payload[31:0], data_sum);
                if (fw.payload[127:32] !== '0) begin
                    stop_run("checksum payload has bits set above bit 31");
                end
                chk_state = WANT_DONE;
            end
            default: begin
                stop_run("frame word arrived after the checksum but before acq_done");
            end
        endcase
    endtask

    // outputs are registered, so they are steady between falling and rising edge
    task automatic observe_outputs();
        if (quiet) begin
            if (sm_idle !== 1'b1 || frame_valid !== 1'b0 || acq_done !== 1'b0 ||
                acq_enabled !== 1'b0) begin
                stop_run("activity seen while acquisition is disarmed");
            end
        end
        // a fill in flight keeps the acquisition enabled
        if (frame_valid === 1'b1 && acq_enabled !== 1'b1) begin
            stop_run("acq_enabled low while frame words are waiting to leave");
        end
        if (acq_done === 1'b1) begin
            if (chk_state != WANT_DONE) begin
                stop_run("acq_done pulse without a finished fill");
            end
            done_count++;
            fill_idx  = fill_idx + 16'd1;
            chk_state = WANT_FILL_HDR;
        end
        // this word transfers on the coming rising edge
        if (frame_valid === 1'b1 && frame_ready) begin
            take_frame(frame_out);
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            stop_run($sformatf("timeout, run still busy after %0d cycles", cycle_count));
        end
        // last rising edge wrote the current word unless in reset
        if (!adc_acq_full_reset) begin
            adc_word = adc_word + 32'd1;
        end
        lfsr        = lfsr_step(lfsr);
        frame_ready = lfsr[0];
        observe_outputs();
    endtask

    task automatic run_row(input stim_row_t row);
        int target;
        acq_enable0   = row.enables[0];
        acq_enable1   = row.enables[1];
        burst_count_0 = row.bc0;
        burst_count_1 = row.bc1;
        exp_type      = row.enables;
        exp_count     = bursts_for_row(row);
        target        = done_count + int'(row.fills);
        // long enough for a held trigger to release DONE and the enables to cross
        repeat (12) next_cycle();
        if (row.enables == '0) begin
            quiet = 1'b1;
        end else begin
            while (sm_idle) begin
                next_cycle();
            end
        end
        trig_word = adc_word;
        acq_trig  = 1'b1;
        repeat (row.hold) next_cycle();
        acq_trig = 1'b0;
        while (done_count < target) begin
            next_cycle();
        end
        repeat (20) next_cycle();
        quiet = 1'b0;
    endtask

    initial begin
        adc_acq_full_reset = 1'b1;
        adc_word           = '0;
        adc_valid          = 1'b1;
        acq_enable0        = 1'b0;
        acq_enable1        = 1'b0;
        acq_trig           = 1'b0;
        burst_count_0      = '0;
        burst_count_1      = '0;
        frame_ready        = 1'b0;
        lfsr               = 16'd52;
        cycle_count        = 0;
        done_count         = 0;
        bursts_left        = 0;
        quiet              = 1'b0;
        first_word         = 1'b0;
        chk_state          = WANT_FILL_HDR;
        fill_idx           = '0;
        exp_type           = '0;
        exp_count          = '0;
        wfm_addr           = '0;
        next_word          = '0;
        data_sum           = '0;
        trig_word          = '0;

        // enables, burst_count_0, burst_count_1, trigger hold cycles, fills
        rows[0] = '{2'd1, 8'd3,  8'd5,  8'd2,   2'd1};
        rows[1] = '{2'd2, 8'd3,  8'd5,  8'd120, 2'd1};
        rows[2] = '{2'd3, 8'd7,  8'd0,  8'd1,   2'd1};
        rows[3] = '{2'd0, 8'd4,  8'd4,  8'd6,   2'd0};
        rows[4] = '{2'd1, 8'd20, 8'd2,  8'd3,   2'd1};
        rows[5] = '{2'd2, 8'd1,  8'd12, 8'd5,   2'd1};
        rows[6] = '{2'd3, 8'd0,  8'd8,  8'd2,   2'd1};

        cycle_limit = 60;
        fills_total = 0;
        for (r = 0; r < NUM_ROWS; r++) begin
            cycle_limit = cycle_limit + row_cycles(rows[r]);
            fills_total = fills_total + int'(rows[r].fills);
        end

        repeat (16) next_cycle();
        adc_acq_full_reset = 1'b0;
        // fill the buffer past the pretrigger window before any trigger
        quiet = 1'b1;
        repeat (20) next_cycle();
        quiet = 1'b0;

        for (r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end

        if (done_count == fills_total && chk_state == WANT_FILL_HDR) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_run($sformatf("mismatch fills done: got %h expected %h",
                               done_count, fills_total));
        end
    end

endmodule

// File: vlog.f
design/adc_acq_pkg.sv
design/sync_fifo.sv
design/adc_acq_sequencer.sv
design/circ_buf_reader.sv
design/frame_assembler.sv
design/adc_acq_top.sv
tb/adc_acq_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal \
    --top-module adc_acq_tb \
    -f vlog.f \
    -o adc_acq_sim
./obj_dir/adc_acq_sim
